// File: design/audio_pkg.sv
package audio_pkg;

    localparam int sample_w  = 24;                 // pcm word
    localparam int coef_w    = 16;                 // q1.15
    localparam int gain_w    = 16;                 // q2.14
    localparam int acc_w     = 48;                 // mac headroom
    localparam int num_bands = 2;                  // 0 low, 1 high
    localparam int band_w    = (num_bands > 1) ? $clog2(num_bands) : 1;

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic signed [coef_w-1:0]   coef_t;
    typedef logic signed [gain_w-1:0]   gain_t;
    typedef logic signed [acc_w-1:0]    acc_t;
    typedef logic        [band_w-1:0]   band_t;

    localparam gain_t unity_gain = 16'sh4000;      // 1.0 in q2.14

    localparam acc_t sample_max = (2 ** (sample_w - 1)) - 1;
    localparam acc_t sample_min = -(2 ** (sample_w - 1));

    // clamp a wide value into the pcm range
    function automatic sample_t sat_sample(input acc_t v);
        if (v > sample_max) return sample_max[sample_w-1:0];   // 0x7fffff
        if (v < sample_min) return sample_min[sample_w-1:0];   // 0x800000
        return v[sample_w-1:0];
    endfunction

endpackage

// File: design/audio_processing.sv
`timescale 1ns/100ps

module audio_processing #(
    parameter int num_taps = 8,
    parameter int bclk_div = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        audio_enable,
    // i2s in
    input  logic                        i2s_bclk,
    input  logic                        i2s_lrclk,
    input  logic                        i2s_d,
    // cpu writes
    input  logic                        coef_wr_en,
    input  audio_pkg::band_t            coef_band,
    input  logic [$clog2(num_taps)-1:0] coef_addr,
    input  audio_pkg::coef_t            coef_data,
    input  logic                        gain_wr_en,
    input  audio_pkg::band_t            gain_band,
    input  audio_pkg::gain_t            gain_data,
    // dac, i2s out
    output logic                        dac_bclk,
    output logic                        dac_lrclk,
    output logic                        dac_data
);
    import audio_pkg::*;

    logic    frame_valid;
    sample_t left_sample, right_sample;
    logic    low_valid;                                     // high band strobe coincides
    sample_t low_left, low_right;
    sample_t high_left, high_right;
    logic    mix_valid;
    sample_t mix_left, mix_right;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline

    i2s_receiver rx (
        .clk (clk), .rst (rst), .audio_enable (audio_enable),
        .i2s_bclk     (i2s_bclk),       // async
        .i2s_lrclk    (i2s_lrclk),      // async
        .i2s_d        (i2s_d),          // async
        .frame_valid  (frame_valid),    // strobe to both bands
        .left_sample  (left_sample),
        .right_sample (right_sample)
    );

    fir_band_filter #(.num_taps (num_taps), .band_index (0)) low_band (
        .clk (clk), .rst (rst), .audio_enable (audio_enable),
        .coef_wr_en (coef_wr_en), .coef_band (coef_band),
        .coef_addr (coef_addr), .coef_data (coef_data),
        .frame_valid (frame_valid), .left_sample (left_sample), .right_sample (right_sample),
        .band_valid (low_valid),        // drives the mixer
        .band_left  (low_left),
        .band_right (low_right)
    );

    fir_band_filter #(.num_taps (num_taps), .band_index (1)) high_band (
        .clk (clk), .rst (rst), .audio_enable (audio_enable),
        .coef_wr_en (coef_wr_en), .coef_band (coef_band),
        .coef_addr (coef_addr), .coef_data (coef_data),
        .frame_valid (frame_valid), .left_sample (left_sample), .right_sample (right_sample),
        .band_valid (),                 // same cycle as low band
        .band_left  (high_left),
        .band_right (high_right)
    );

    eq_band_mixer mixer (
        .clk (clk), .rst (rst),
        .gain_wr_en (gain_wr_en), .gain_band (gain_band), .gain_data (gain_data),
        .band_valid (low_valid),
        .low_left   (low_left),  .low_right  (low_right),
        .high_left  (high_left), .high_right (high_right),
        .mix_valid  (mix_valid), .mix_left   (mix_left), .mix_right (mix_right)
    );

    i2s_transmitter #(.bclk_div (bclk_div)) tx (
        .clk (clk), .rst (rst), .audio_enable (audio_enable),
        .mix_valid (mix_valid), .mix_left (mix_left), .mix_right (mix_right),
        .dac_bclk  (dac_bclk),          // own bit clock
        .dac_lrclk (dac_lrclk),
        .dac_data  (dac_data)
    );

endmodule

// File: design/eq_band_mixer.sv
`timescale 1ns/100ps

module eq_band_mixer (
    input  logic               clk,
    input  logic               rst,
    input  logic               gain_wr_en,
    input  audio_pkg::band_t   gain_band,
    input  audio_pkg::gain_t   gain_data,          // q2.14
    input  logic               band_valid,         // low band strobe
    input  audio_pkg::sample_t low_left,
    input  audio_pkg::sample_t low_right,
    input  audio_pkg::sample_t high_left,
    input  audio_pkg::sample_t high_right,
    output logic               mix_valid,
    output audio_pkg::sample_t mix_left,
    output audio_pkg::sample_t mix_right
);
    import audio_pkg::*;

    gain_t gain_r [num_bands];
    acc_t  prod_ll;                 // low band, left
    acc_t  prod_lr;
    acc_t  prod_hl;                 // high band, left
    acc_t  prod_hr;
    acc_t  sum_l;
    acc_t  sum_r;
    logic  s1_valid;

    ////////////////////////////////////////////////////////////////////////////
    // gain registers

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_bands; i++)
                gain_r[i] <= unity_gain;
        end else if (gain_wr_en) begin
            gain_r[gain_band] <= gain_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 1, weight and add

    always_comb begin
        prod_ll = gain_r[0] * low_left;                     // 40 bit product
        prod_lr = gain_r[0] * low_right;
        prod_hl = gain_r[1] * high_left;
        prod_hr = gain_r[1] * high_right;
    end

    always_ff @(posedge clk) begin
        if (band_valid) begin
            sum_l <= prod_ll + prod_hl;                    // full width, no wrap
            sum_r <= prod_lr + prod_hr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2, rescale and clamp

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            mix_left  <= sat_sample(sum_l >>> 14);         // q2.14 back to pcm
            mix_right <= sat_sample(sum_r >>> 14);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            mix_valid <= 1'b0;
        end else begin
            s1_valid  <= band_valid;
            mix_valid <= s1_valid;                         // 2 after band strobe
        end
    end

endmodule

// File: design/fir_band_filter.sv
`timescale 1ns/100ps

module fir_band_filter #(
    parameter int num_taps   = 8,                   // 2 .. 32
    parameter int band_index = 0                    // 0 low, 1 high
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        audio_enable,
    input  logic                        coef_wr_en,
    input  audio_pkg::band_t            coef_band,
    input  logic [$clog2(num_taps)-1:0] coef_addr,
    input  audio_pkg::coef_t            coef_data,
    input  logic                        frame_valid,
    input  audio_pkg::sample_t          left_sample,
    input  audio_pkg::sample_t          right_sample,
    output logic                        band_valid,
    output audio_pkg::sample_t          band_left,
    output audio_pkg::sample_t          band_right
);
    import audio_pkg::*;

    localparam int addr_w = $clog2(num_taps);

    coef_t       coef_mem [num_taps];
    sample_t     hist_l   [num_taps];   // [0] newest
    sample_t     hist_r   [num_taps];
    logic        coef_hit;
    logic        busy;
    logic        chan;                  // 0 left, 1 right
    logic [addr_w-1:0] tap;
    logic        tap_end;
    sample_t     tap_x;
    acc_t        prod;
    acc_t        acc;
    logic        p_valid;
    logic        p_first;
    logic        p_last;
    logic        p_chan;
    logic        a_last;
    logic        a_chan;

    ////////////////////////////////////////////////////////////////////////////
    // coefficient memory and history

    assign coef_hit = coef_wr_en && (coef_band == band_t'(band_index));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_taps; i++)
                coef_mem[i] <= '0;
        end else if (coef_hit) begin
            coef_mem[coef_addr] <= coef_data;             // seen by next tap read
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !audio_enable) begin
            for (int i = 0; i < num_taps; i++) begin
                hist_l[i] <= '0;
                hist_r[i] <= '0;
            end
        end else if (frame_valid) begin
            hist_l[0] <= left_sample;
            hist_r[0] <= right_sample;
            for (int i = 1; i < num_taps; i++) begin
                hist_l[i] <= hist_l[i-1];
                hist_r[i] <= hist_r[i-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tap sequencer, left pass then right pass

    assign tap_end = (tap == addr_w'(num_taps - 1));

    always_ff @(posedge clk) begin
        if (rst || !audio_enable) begin
            busy <= 1'b0;
            chan <= 1'b0;
            tap  <= '0;
        end else if (frame_valid) begin
            busy <= 1'b1;
            chan <= 1'b0;
            tap  <= '0;
        end else if (busy) begin
            if (tap_end) begin
                tap  <= '0;
                chan <= ~chan;
                if (chan)
                    busy <= 1'b0;                          // both channels done
            end else begin
                tap <= tap + 1'b1;
            end
        end
    end

    assign tap_x = chan ? hist_r[tap] : hist_l[tap];

    // tags follow the product and accumulate stages
    always_ff @(posedge clk) begin
        if (rst || !audio_enable) begin
            p_valid    <= 1'b0;
            p_first    <= 1'b0;
            p_last     <= 1'b0;
            p_chan     <= 1'b0;
            a_last     <= 1'b0;
            a_chan     <= 1'b0;
            band_valid <= 1'b0;
        end else begin
            p_valid    <= busy;
            p_first    <= busy && (tap == '0);
            p_last     <= busy && tap_end;
            p_chan     <= chan;
            a_last     <= p_valid && p_last;               // acc holds a full sum
            a_chan     <= p_chan;
            band_valid <= a_last && a_chan;                // 2*taps+3 after frame
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // mac datapath

    always_ff @(posedge clk) begin
        prod <= coef_mem[tap] * tap_x;                     // 16x24 into 48 bits
        if (p_valid)
            acc <= p_first ? prod : acc + prod;
        if (a_last && !a_chan)
            band_left <= sat_sample(acc >>> 15);           // drop q1.15 scale
        if (a_last && a_chan)
            band_right <= sat_sample(acc >>> 15);
    end

endmodule

// File: design/i2s_receiver.sv
`timescale 1ns/100ps

module i2s_receiver (
    input  logic               clk,
    input  logic               rst,
    input  logic               audio_enable,
    input  logic               i2s_bclk,            // async from codec
    input  logic               i2s_lrclk,           // low = left slot
    input  logic               i2s_d,
    output logic               frame_valid,         // one clk strobe
    output audio_pkg::sample_t left_sample,
    output audio_pkg::sample_t right_sample
);
    import audio_pkg::*;

    logic [2:0] bclk_sync;          // [1] synced, [2] previous
    logic [2:0] lrclk_sync;
    logic [1:0] d_sync;
    logic       bclk_rise;
    logic       lr_rise;
    logic       lr_fall;
    logic [5:0] bit_cnt;            // rising edges seen in slot
    logic       armed;              // a full left slot has started
    logic       frame_pend;
    sample_t    shift_sr;
    sample_t    left_word;
    sample_t    right_word;

    ////////////////////////////////////////////////////////////////////////////
    // input synchronizers

    always_ff @(posedge clk) begin
        if (rst) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            d_sync     <= '0;
        end else begin
            bclk_sync  <= {bclk_sync[1:0], i2s_bclk};
            lrclk_sync <= {lrclk_sync[1:0], i2s_lrclk};
            d_sync     <= {d_sync[0], i2s_d};
        end
    end

    assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];
    assign lr_rise   = lrclk_sync[1] & ~lrclk_sync[2];     // left slot ends
    assign lr_fall   = ~lrclk_sync[1] & lrclk_sync[2];     // right slot ends

    ////////////////////////////////////////////////////////////////////////////
    // slot bit counter and frame strobe

    always_ff @(posedge clk) begin
        if (rst || !audio_enable) begin
            bit_cnt     <= '0;
            armed       <= 1'b0;
            frame_pend  <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_pend  <= lr_fall & armed;                // skip partial first frame
            frame_valid <= frame_pend;
            if (lr_fall)
                armed <= 1'b1;
            if (lr_rise || lr_fall)
                bit_cnt <= '0;                             // new slot
            else if (bclk_rise && bit_cnt != 6'd63)
                bit_cnt <= bit_cnt + 6'd1;                 // saturates past slot end
        end
    end

    // edge 0 carries the last bit of the previous slot, 1..24 are data
    always_ff @(posedge clk) begin
        if (audio_enable && bclk_rise && bit_cnt >= 6'd1 && bit_cnt <= 6'(sample_w))
            shift_sr <= {shift_sr[sample_w-2:0], d_sync[1]};   // msb first
        if (lr_rise)
            left_word <= shift_sr;
        if (lr_fall)
            right_word <= shift_sr;
        if (frame_pend) begin
            left_sample  <= left_word;
            right_sample <= right_word;
        end
    end

endmodule

// File: design/i2s_transmitter.sv
`timescale 1ns/100ps

module i2s_transmitter #(
    parameter int bclk_div = 4                      // clk cycles per bclk half
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               audio_enable,
    input  logic               mix_valid,
    input  audio_pkg::sample_t mix_left,
    input  audio_pkg::sample_t mix_right,
    output logic               dac_bclk,
    output logic               dac_lrclk,           // low = left slot
    output logic               dac_data
);
    import audio_pkg::*;

    localparam int div_w     = $clog2(bclk_div + 1);
    localparam int slot_bits = 32;

    logic [div_w-1:0]      div_cnt;
    logic [4:0]            bit_cnt;                 // falling edges in slot
    logic [2*sample_w-1:0] hold;                    // newest frame, left high
    logic [2*sample_w-1:0] tx_sr;                   // frame on the wire
    logic                  half_end;
    logic                  bclk_fall;

    assign half_end  = (div_cnt == div_w'(bclk_div - 1));
    assign bclk_fall = half_end & dac_bclk;

    ////////////////////////////////////////////////////////////////////////////
    // bit clock, word clock and serial data

    always_ff @(posedge clk) begin
        if (rst || !audio_enable) begin
            div_cnt   <= '0;
            dac_bclk  <= 1'b0;
            dac_lrclk <= 1'b0;                             // restart in a left slot
            dac_data  <= 1'b0;
            bit_cnt   <= '0;
            hold      <= '0;                               // zeros until data
            tx_sr     <= '0;
        end else begin
            if (mix_valid)
                hold <= {mix_left, mix_right};             // older frame dropped

            if (half_end) begin
                div_cnt  <= '0;
                dac_bclk <= ~dac_bclk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (bclk_fall) begin
                if (bit_cnt == 5'(slot_bits - 1)) begin
                    bit_cnt   <= '0;
                    dac_lrclk <= ~dac_lrclk;
                    dac_data  <= 1'b0;                     // last pad bit
                    if (dac_lrclk)
                        tx_sr <= hold;                     // left slot starts
                end else begin
                    bit_cnt <= bit_cnt + 5'd1;
                    if (bit_cnt < 5'(sample_w)) begin
                        dac_data <= tx_sr[2*sample_w-1];   // msb first
                        tx_sr    <= tx_sr << 1;
                    end else begin
                        dac_data <= 1'b0;                  // 8 bit pad
                    end
                end
            end
        end
    end

endmodule

// File: verif/audio_processing_tb.sv
`timescale 1ns/100ps

module audio_processing_tb;
    import audio_pkg::*;

    localparam int     num_taps     = 8;
    localparam int     bclk_div     = 4;
    localparam int     frame_clks   = 64 * 2 * bclk_div;       // one dac frame
    localparam int     mix_lat_clks = 2 * num_taps + 9;        // closing edge to mix strobe
    localparam int     num_steps    = 64;                       // frames sent plus spare
    localparam longint watchdog_ns  = longint'(num_steps) * 4 * frame_clks * 20 + 100000;

    logic    clk, rst, audio_enable;
    logic    i2s_bclk, i2s_lrclk, i2s_d;
    logic    coef_wr_en, gain_wr_en;
    band_t   coef_band, gain_band;
    logic [$clog2(num_taps)-1:0] coef_addr;
    coef_t   coef_data;
    gain_t   gain_data;
    logic    dac_bclk, dac_lrclk, dac_data;

    logic [31:0] lfsr_state = 32'h7e2b6da7;
    longint      m_coef [2][num_taps];                          // reference model state
    longint      m_gain [2];
    longint      m_hl   [num_taps];
    longint      m_hr   [num_taps];
    logic [23:0] out_l, out_r;                                  // last decoded dac frame
    longint      exp_l, exp_r;

    audio_processing #(.num_taps (num_taps), .bclk_div (bclk_div)) uut (
        .clk (clk), .rst (rst), .audio_enable (audio_enable),
        .i2s_bclk (i2s_bclk), .i2s_lrclk (i2s_lrclk), .i2s_d (i2s_d),
        .coef_wr_en (coef_wr_en), .coef_band (coef_band),
        .coef_addr (coef_addr), .coef_data (coef_data),
        .gain_wr_en (gain_wr_en), .gain_band (gain_band), .gain_data (gain_data),
        .dac_bclk (dac_bclk), .dac_lrclk (dac_lrclk), .dac_data (dac_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                                 // 20 ns period
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within the expected run time");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};                // one step per bit
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic longint sat24(input longint v);
        if (v > 64'sd8388607) return 64'sd8388607;
        if (v < -64'sd8388608) return -64'sd8388608;
        return v;
    endfunction

    function automatic longint fir_out(input int band, input bit ch);
        longint acc;
        acc = 0;
        for (int k = 0; k < num_taps; k++)
            acc += m_coef[band][k] * (ch ? m_hr[k] : m_hl[k]);  // k = age of sample
        return sat24(acc >>> 15);
    endfunction

    function automatic longint mix_out(input bit ch);
        return sat24((m_gain[0] * fir_out(0, ch) + m_gain[1] * fir_out(1, ch)) >>> 14);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic model_clear();
        for (int k = 0; k < num_taps; k++) begin
            m_hl[k] = 0;
            m_hr[k] = 0;
        end
    endtask

    task automatic write_coef(input band_t b, input int a, input coef_t d);
        @(negedge clk);
        coef_wr_en = 1'b1;
        coef_band  = b;
        coef_addr  = a;
        coef_data  = d;
        @(negedge clk);
        coef_wr_en = 1'b0;
        m_coef[b][a] = longint'(d);
    endtask

    task automatic write_gain(input band_t b, input gain_t d);
        @(negedge clk);
        gain_wr_en = 1'b1;
        gain_band  = b;
        gain_data  = d;
        @(negedge clk);
        gain_wr_en = 1'b0;
        m_gain[b] = longint'(d);
    endtask

    // one word clock pulse so the receiver has seen a slot boundary
    task automatic prime_receiver();
        @(negedge clk) i2s_lrclk = 1'b1;
        repeat (8) @(negedge clk);
        i2s_lrclk = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic drive_i2s(input sample_t l, input sample_t r);
        logic [63:0] stream;
        stream = {l, 8'h00, r, 8'h00};
        for (int p = 0; p < 64; p++) begin
            @(negedge clk);
            i2s_bclk  = 1'b0;
            i2s_lrclk = (p >= 32);                              // right slot high
            i2s_d     = (p == 0) ? 1'b0 : stream[64-p];         // data one bit late
            repeat (4) @(negedge clk);
            i2s_bclk = 1'b1;
            repeat (3) @(negedge clk);
        end
        @(negedge clk);
        i2s_bclk  = 1'b0;
        i2s_lrclk = 1'b0;                                       // closes the right slot
        i2s_d     = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic read_dac(output logic [23:0] l, output logic [23:0] r);
        @(negedge dac_lrclk);                                   // left slot starts
        for (int k = 0; k < 57; k++) begin
            @(posedge dac_bclk);
            if (k >= 1 && k <= 24)
                l = {l[22:0], dac_data};
            else if (k >= 33)
                r = {r[22:0], dac_data};
        end
    endtask

    task automatic process_frame(input sample_t l, input sample_t r);
        drive_i2s(l, r);
        for (int k = num_taps - 1; k > 0; k--) begin
            m_hl[k] = m_hl[k-1];
            m_hr[k] = m_hr[k-1];
        end
        m_hl[0] = longint'(l);
        m_hr[0] = longint'(r);
        exp_l = mix_out(0);
        exp_r = mix_out(1);
        repeat (mix_lat_clks) @(negedge clk);                   // past the mix strobe
        read_dac(out_l, out_r);
        check("dac left", out_l, exp_l[23:0]);
        check("dac right", out_r, exp_r[23:0]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_reset_enable();
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            check("dac_bclk", dac_bclk, 0);
            check("dac_lrclk", dac_lrclk, 0);
            check("dac_data", dac_data, 0);
        end
        audio_enable = 1'b1;
        model_clear();
        prime_receiver();
        read_dac(out_l, out_r);
        check("dac left", out_l, 0);                            // nothing mixed yet
        check("dac right", out_r, 0);
    endtask

    task automatic test_single_tap();
        sample_t l, r;
        longint  t;
        for (int k = 0; k < num_taps; k++)
            write_coef(0, k, (k == 0) ? 16'sh4000 : 16'sh0000);
        write_gain(0, 16'sh4000);
        write_gain(1, 16'sh0000);
        for (int i = 0; i < 3; i++) begin
            l = rand_bits(24);
            r = rand_bits(24);
            process_frame(l, r);
            t = longint'(l) >>> 1;
            check("half left", out_l, t[23:0]);
            t = longint'(r) >>> 1;
            check("half right", out_r, t[23:0]);
        end
    endtask

    task automatic test_two_band_mix();
        for (int b = 0; b < 2; b++)
            for (int k = 0; k < num_taps; k++)
                write_coef(b, k, rand_bits(16));
        write_gain(0, rand_bits(16));
        write_gain(1, rand_bits(16));
        for (int i = 0; i < 6; i++)
            process_frame(rand_bits(24), rand_bits(24));        // model carries history
    endtask

    task automatic test_saturation();
        for (int b = 0; b < 2; b++) begin
            for (int k = 0; k < num_taps; k++)
                write_coef(b, k, 16'sh7fff);
            write_gain(b, 16'sh7fff);
        end
        for (int i = 0; i < num_taps; i++)
            process_frame(24'sh7fffff, 24'sh7fffff);
        check("sat left", out_l, 24'h7fffff);
        check("sat right", out_r, 24'h7fffff);
        for (int i = 0; i < num_taps; i++)
            process_frame(24'sh800000, 24'sh800000);
        check("sat left", out_l, 24'h800000);
        check("sat right", out_r, 24'h800000);
    endtask

    task automatic impulse_run(input bit right_side);
        longint c;
        for (int i = 0; i < num_taps; i++)
            process_frame(0, 0);                                // flush history
        for (int k = 0; k < num_taps; k++) begin
            if (k == 0 && !right_side)
                process_frame(24'sh008000, 0);                  // 1.0 after q1.15 scale
            else if (k == 0)
                process_frame(0, 24'sh008000);
            else
                process_frame(0, 0);
            c = m_coef[0][k];
            if (right_side) begin
                check("impulse right", out_r, c[23:0]);
                check("quiet left", out_l, 0);
            end else begin
                check("impulse left", out_l, c[23:0]);
                check("quiet right", out_r, 0);
            end
        end
    endtask

    task automatic test_channel_independence();
        for (int k = 0; k < num_taps; k++)
            write_coef(0, k, rand_bits(16));
        write_gain(0, 16'sh4000);
        write_gain(1, 16'sh0000);
        impulse_run(1'b0);
        impulse_run(1'b1);
    endtask

    task automatic test_history_clear();
        write_gain(0, 16'sh2000);
        write_gain(1, 16'sh2000);                               // both bands audible
        for (int i = 0; i < 2; i++)
            process_frame(rand_bits(24), rand_bits(24));        // fill both histories
        @(negedge clk) audio_enable = 1'b0;
        repeat (20) @(negedge clk);
        check("dac_bclk", dac_bclk, 0);
        check("dac_lrclk", dac_lrclk, 0);
        check("dac_data", dac_data, 0);
        audio_enable = 1'b1;
        model_clear();                                          // filters start empty
        prime_receiver();
        process_frame(rand_bits(24), rand_bits(24));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        rst          = 1'b1;
        audio_enable = 1'b0;
        i2s_bclk     = 1'b0;
        i2s_lrclk    = 1'b0;
        i2s_d        = 1'b0;
        coef_wr_en   = 1'b0;
        coef_band    = '0;
        coef_addr    = '0;
        coef_data    = '0;
        gain_wr_en   = 1'b0;
        gain_band    = '0;
        gain_data    = '0;
        for (int b = 0; b < 2; b++) begin
            m_gain[b] = 64'sh4000;                              // unity after reset
            for (int k = 0; k < num_taps; k++)
                m_coef[b][k] = 0;
        end
        model_clear();
        repeat (16) @(posedge clk);
        @(negedge clk) rst = 1'b0;

        test_reset_enable();
        test_single_tap();
        test_two_band_mix();
        test_saturation();
        test_channel_independence();
        test_history_clear();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: vlog.f
design/audio_pkg.sv
design/i2s_receiver.sv
design/fir_band_filter.sv
design/eq_band_mixer.sv
design/i2s_transmitter.sv
design/audio_processing.sv
verif/audio_processing_tb.sv
